// ==== filelist.f ====
logic/nnLayerPkg.sv
logic/sampleAssembler.sv
logic/neuronNode.sv
logic/classSelect.sv
logic/denseLayerTop.sv
verif/clockGen.sv
verif/denseLayer_asserts.sv
verif/denseLayerTb.sv

// ==== verif/denseLayerTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module denseLayerTb;

	typedef struct packed
	{
		nnLayerPkg::featureVec features;
		logic gapMode;
		logic [nnLayerPkg::classWidth-1:0] classIdx;
	} stimEntry;

	localparam int numEntries = 9;
	localparam int resultTimeout = 50;
	localparam int resultLatency = 5;

	// Features with input 0 in the low byte, gap flag, expected class
	localparam stimEntry stimTable [numEntries] = '{
		'{64'h0000_0000_0000_0000, 1'b0, 2'd0},
		'{64'h0000_0000_0000_0001, 1'b0, 2'd3},
		'{64'h0000_0000_0000_0100, 1'b0, 2'd1},
		'{64'h0100_0000_0000_0000, 1'b1, 2'd0},
		'{64'h0000_0100_0000_0000, 1'b1, 2'd1},
		'{64'h0001_0000_0000_0000, 1'b0, 2'd2},
		'{64'h0000_0000_0000_0200, 1'b1, 2'd0},
		'{64'h0000_0000_0003_0002, 1'b0, 2'd0},
		'{64'h0000_00FF_FF00_0000, 1'b1, 2'd1}
	};

	logic clk;
	logic reset;
	logic signed [7:0] byteIn;
	logic byteStrobe;
	logic sampleStart;
	logic resultValid;
	nnLayerPkg::layerResult result;
	int seed = 35639;
	int cycleCount = 0;
	int errorCount = 0;
	int pendIdx [$];
	int pendCycle [$];

	clockGen clocks (.clk(clk), .reset(reset));

	denseLayerTop DUT
	(
		.clk(clk),
		.reset(reset),
		.byteIn(byteIn),
		.byteStrobe(byteStrobe),
		.sampleStart(sampleStart),
		.resultValid(resultValid),
		.result(result)
	);

	always @(posedge clk) cycleCount <= cycleCount + 1;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic nnLayerPkg::activationVec modelActs(input nnLayerPkg::featureVec x);
		logic [7:0] sum;
		logic [15:0] prod;
		nnLayerPkg::activationVec acts;
		for (int n = 0; n < nnLayerPkg::numNodes; n++)
		begin
			sum = nnLayerPkg::biasTable[n];
			for (int i = 0; i < nnLayerPkg::numInputs; i++)
			begin
				prod = $signed(x[i*8 +: 8]) * $signed(nnLayerPkg::weightTable[n][i]);
				sum = sum + prod[7:0];
			end
			acts[n*8 +: 8] = sum[7] ? 8'd0 : sum;
		end
		return acts;
	endfunction

	// Lowest index holding the maximum
	function automatic logic [1:0] argmaxActs(input nnLayerPkg::activationVec a);
		logic [7:0] maxVal;
		int idx;
		maxVal = 8'd0;
		idx = 0;
		for (int n = 0; n < nnLayerPkg::numNodes; n++)
		begin
			if (a[n*8 +: 8] > maxVal)
			begin
				maxVal = a[n*8 +: 8];
			end
		end
		for (int n = nnLayerPkg::numNodes - 1; n >= 0; n--)
		begin
			if (a[n*8 +: 8] == maxVal)
			begin
				idx = n;
			end
		end
		return idx[1:0];
	endfunction

	task automatic failRun();
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
		begin
			errorCount++;
			$display("CHECK FAILED %s: got %0h expected %0h", name, actual, expected);
			failRun();
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus and result collection
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic driveByte(input logic [7:0] value, input logic start, input logic gapMode);
		int gaps;
		gaps = gapMode ? ($unsigned($random(seed)) % 3) : 0;
		repeat (gaps)
		begin
			@(negedge clk);
			byteStrobe = 1'b0;
			sampleStart = 1'b0;
		end
		@(negedge clk);
		byteIn = value;
		byteStrobe = 1'b1;
		sampleStart = start;
	endtask

	task automatic sendSample(input int idx);
		for (int b = 0; b < nnLayerPkg::numInputs; b++)
		begin
			driveByte(stimTable[idx].features[b*8 +: 8], b == 0, stimTable[idx].gapMode);
		end
		pendIdx.push_back(idx);
		pendCycle.push_back(cycleCount);
	endtask

	task automatic driveAll();
		for (int i = 0; i < numEntries; i++)
		begin
			sendSample(i);
		end
		// Three stray bytes that the next start drops
		driveByte(8'h7F, 1'b1, 1'b0);
		driveByte(8'h55, 1'b0, 1'b0);
		driveByte(8'h80, 1'b0, 1'b0);
		sendSample(2);
		@(negedge clk);
		byteStrobe = 1'b0;
		sampleStart = 1'b0;
	endtask

	task automatic collectResult();
		int waited;
		int idx;
		int due;
		nnLayerPkg::activationVec expActs;
		waited = 0;
		@(negedge clk);
		while (resultValid !== 1'b1)
		begin
			if (waited == resultTimeout)
			begin
				$display("Timeout: no result arrived within %0d cycles", resultTimeout);
				failRun();
			end
			waited++;
			@(negedge clk);
		end
		if (pendIdx.size() == 0)
		begin
			$display("A result arrived with no sample pending");
			failRun();
		end
		idx = pendIdx.pop_front();
		due = pendCycle.pop_front();
		expActs = modelActs(stimTable[idx].features);
		checkValue("latency", cycleCount - due, resultLatency);
		checkValue("result.acts", result.acts, expActs);
		checkValue("result.classIdx", result.classIdx, stimTable[idx].classIdx);
		checkValue("model class", argmaxActs(expActs), stimTable[idx].classIdx);
	endtask

	initial
	begin
		int waited;
		byteIn = '0;
		byteStrobe = 1'b0;
		sampleStart = 1'b0;
		waited = 0;
		@(negedge clk);
		while (reset)
		begin
			checkValue("resultValid", resultValid, 1'b0);
			checkValue("result", result, '0);
			if (waited == 20)
			begin
				$display("Reset was never released");
				failRun();
			end
			waited++;
			@(negedge clk);
		end
		checkValue("resultValid", resultValid, 1'b0);
		checkValue("result", result, '0);
		fork
			driveAll();
			repeat (numEntries + 1) collectResult();
		join
		// No extra result once the stream is idle
		repeat (20)
		begin
			@(negedge clk);
			checkValue("resultValid", resultValid, 1'b0);
		end
		if (errorCount == 0)
		begin
			$display("NO ERRORS");
		end
		else
		begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/denseLayer_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module denseLayerAsserts
(
	input logic clk,
	input logic reset,
	input logic resultValid,
	input nnLayerPkg::layerResult result
);

	// Lowest index holding the largest activation
	function automatic logic pointsAtMax(input nnLayerPkg::layerResult r);
		logic [nnLayerPkg::dataWidth-1:0] picked;
		logic [nnLayerPkg::dataWidth-1:0] other;
		logic ok;
		picked = r.acts[r.classIdx*nnLayerPkg::dataWidth +: nnLayerPkg::dataWidth];
		ok = !$isunknown(r.classIdx);
		for (int n = 0; n < nnLayerPkg::numNodes; n++)
		begin
			other = r.acts[n*nnLayerPkg::dataWidth +: nnLayerPkg::dataWidth];
			if (other > picked || (n < r.classIdx && other == picked))
			begin
				ok = 1'b0;
			end
		end
		return ok;
	endfunction

	quietInReset: assert property (@(posedge clk) reset && $past(reset) |-> !resultValid)
		else $error("resultValid high during reset");

	singlePulse: assert property (@(posedge clk) disable iff (reset)
		resultValid |=> !resultValid)
		else $error("resultValid high for two cycles in a row");

	classIsMax: assert property (@(posedge clk) disable iff (reset)
		pointsAtMax(result))
		else $error("class index does not name the largest activation");

endmodule

bind denseLayerTop denseLayerAsserts asserts
(
	.clk(clk),
	.reset(reset),
	.resultValid(resultValid),
	.result(result)
);

`default_nettype wire

// ==== verif/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen
(
	output logic clk,
	output logic reset
);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// Reset held over eight rising edges
	initial
	begin
		reset = 1'b1;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== logic/denseLayerTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module denseLayerTop
(
	input logic clk,
	input logic reset,
	input logic signed [nnLayerPkg::dataWidth-1:0] byteIn,
	input logic byteStrobe,
	input logic sampleStart,
	output logic resultValid,
	output nnLayerPkg::layerResult result
);

	nnLayerPkg::featureVec vec;
	logic vecValid;
	wire nnLayerPkg::activationVec acts;

	sampleAssembler assembler
	(
		.clk(clk),
		.reset(reset),
		.byteIn(byteIn),
		.byteStrobe(byteStrobe),
		.sampleStart(sampleStart),
		.vec(vec),
		.vecValid(vecValid)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// One node per activation byte
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	for (genvar g = 0; g < nnLayerPkg::numNodes; g++)
	begin : nodes
		neuronNode
		#(
			.nodeIndex(g)
		)
		node
		(
			.clk(clk),
			.reset(reset),
			.vec(vec),
			.act(acts[g*nnLayerPkg::dataWidth +: nnLayerPkg::dataWidth])
		);
	end

	classSelect selector
	(
		.clk(clk),
		.reset(reset),
		.vecValid(vecValid),
		.acts(acts),
		.resultValid(resultValid),
		.result(result)
	);

endmodule

`default_nettype wire

// ==== logic/classSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

module classSelect
(
	input logic clk,
	input logic reset,
	input logic vecValid,
	input nnLayerPkg::activationVec acts,
	output logic resultValid,
	output nnLayerPkg::layerResult result
);

	logic [nnLayerPkg::nodeLatency-1:0] validPipe;
	logic alignedValid;
	logic [nnLayerPkg::classWidth-1:0] bestIdx;
	logic [nnLayerPkg::dataWidth-1:0] bestAct;

	// Valid delay matching the node pipeline
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[nnLayerPkg::nodeLatency-2:0], vecValid};
		end
	end

	assign alignedValid = validPipe[nnLayerPkg::nodeLatency-1];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Argmax over unsigned activations
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		bestIdx = '0;
		bestAct = acts[nnLayerPkg::dataWidth-1:0];
		for (int n = 1; n < nnLayerPkg::numNodes; n++)
		begin
			// Strict compare, so equal maxima keep the lower index
			if (acts[n*nnLayerPkg::dataWidth +: nnLayerPkg::dataWidth] > bestAct)
			begin
				bestIdx = n[nnLayerPkg::classWidth-1:0];
				bestAct = acts[n*nnLayerPkg::dataWidth +: nnLayerPkg::dataWidth];
			end
		end
	end

	// Result held until the next aligned pulse
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			resultValid <= 1'b0;
			result <= '0;
		end
		else
		begin
			resultValid <= alignedValid;
			if (alignedValid)
			begin
				result.classIdx <= bestIdx;
				result.acts <= acts;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/neuronNode.sv ====
`timescale 1ns/1ps
`default_nettype none

module neuronNode
#(
	parameter int unsigned nodeIndex = 0
)
(
	input logic clk,
	input logic reset,
	input nnLayerPkg::featureVec vec,
	output logic [nnLayerPkg::dataWidth-1:0] act
);

	nnLayerPkg::featureVec vecReg;
	logic signed [nnLayerPkg::dataWidth-1:0] products [nnLayerPkg::numInputs];
	logic signed [nnLayerPkg::dataWidth-1:0] sumNext;
	logic signed [nnLayerPkg::dataWidth-1:0] sumReg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Products and sum wrapping at 8 bits
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Only the low byte of each product survives
	always_comb
	begin
		for (int i = 0; i < nnLayerPkg::numInputs; i++)
		begin
			products[i] = $signed(vecReg[i*nnLayerPkg::dataWidth +: nnLayerPkg::dataWidth])
				* nnLayerPkg::weightTable[nodeIndex][i];
		end
	end

	// Sum modulo 256
	always_comb
	begin
		sumNext = nnLayerPkg::biasTable[nodeIndex];
		for (int i = 0; i < nnLayerPkg::numInputs; i++)
		begin
			sumNext = sumNext + products[i];
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Three register stages
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			vecReg <= '0;
			sumReg <= '0;
			act <= '0;
		end
		else
		begin
			// Input sampled every cycle without an enable
			vecReg <= vec;
			sumReg <= sumNext;
			// ReLU on the sign bit
			if (sumReg[nnLayerPkg::dataWidth-1])
			begin
				act <= '0;
			end
			else
			begin
				act <= sumReg;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/sampleAssembler.sv ====
`timescale 1ns/1ps
`default_nettype none

module sampleAssembler
(
	input logic clk,
	input logic reset,
	input logic signed [nnLayerPkg::dataWidth-1:0] byteIn,
	input logic byteStrobe,
	input logic sampleStart,
	output nnLayerPkg::featureVec vec,
	output logic vecValid
);

	logic [$clog2(nnLayerPkg::numInputs)-1:0] bytePos;
	logic [$clog2(nnLayerPkg::numInputs)-1:0] curPos;
	logic [(nnLayerPkg::numInputs-1)*nnLayerPkg::dataWidth-1:0] shiftReg;
	logic lastByte;

	// A start strobe always lands at position zero
	assign curPos = sampleStart ? '0 : bytePos;
	assign lastByte = byteStrobe && (curPos == nnLayerPkg::numInputs - 1);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Byte position and shift register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			bytePos <= '0;
			shiftReg <= '0;
		end
		else if (byteStrobe)
		begin
			// Newest byte enters at the top, oldest drifts down
			shiftReg <= {byteIn, shiftReg[$bits(shiftReg)-1:nnLayerPkg::dataWidth]};
			if (lastByte)
			begin
				bytePos <= '0;
			end
			else
			begin
				bytePos <= curPos + 1'b1;
			end
		end
		else if (sampleStart)
		begin
			bytePos <= '0;
		end
	end

	// Vector load on the eighth byte
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			vec <= '0;
			vecValid <= 1'b0;
		end
		else
		begin
			vecValid <= lastByte;
			if (lastByte)
			begin
				vec <= {byteIn, shiftReg};
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/nnLayerPkg.sv ====
`default_nettype none

package nnLayerPkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Layer sizes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int numInputs = 8;
	localparam int numNodes = 4;
	localparam int dataWidth = 8;
	localparam int classWidth = $clog2(numNodes);

	// Vector valid to activation valid, in cycles
	localparam int nodeLatency = 3;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Fixed weights, row per node, column per input
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam byte weightTable [numNodes][numInputs] = '{
		'{ 36,  24,  -9,  19,  -8, -58,   5,  69},
		'{ 40, 100,  20,  -5, -42,  80, -20,   1},
		'{ 17,  23, -23, -41,  23, -70,  36,  17},
		'{ 61,  90, -22, -34,  10, -38,  13,  -7}
	};

	// Nodes 0 and 2 share a bias, so a zero sample ties them
	localparam byte biasTable [numNodes] = '{13, -4, 13, 0};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Data structs
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Input 0 sits in the low byte
	typedef struct packed
	{
		logic signed [dataWidth-1:0] in7;
		logic signed [dataWidth-1:0] in6;
		logic signed [dataWidth-1:0] in5;
		logic signed [dataWidth-1:0] in4;
		logic signed [dataWidth-1:0] in3;
		logic signed [dataWidth-1:0] in2;
		logic signed [dataWidth-1:0] in1;
		logic signed [dataWidth-1:0] in0;
	} featureVec;

	// Node 0 sits in the low byte
	typedef struct packed
	{
		logic [dataWidth-1:0] node3;
		logic [dataWidth-1:0] node2;
		logic [dataWidth-1:0] node1;
		logic [dataWidth-1:0] node0;
	} activationVec;

	typedef struct packed
	{
		logic [classWidth-1:0] classIdx;
		activationVec acts;
	} layerResult;

endpackage

`default_nettype wire
